// File: ram_access_pkg.sv
/*
 * Shared definitions for the two-port RAM access wrapper:
 * default array sizes, address and pattern widths,
 * the address type and the access-mode enum.
 */

`default_nettype none

package ram_access_pkg;

  // --------------------
  // default sizes
  // --------------------

  // number of words in the array
  parameter int ram_depth_default = 80;

  // functional data width seen on di and dout
  parameter int data_width_default = 65;

  // array word, functional data plus one spare bit written as zero
  parameter int word_width_default = 66;

  // enough bits to reach every word
  parameter int addr_width = 7;

  // mbist data pattern, replicated across the whole word
  parameter int pattern_width = 2;

  // --------------------
  // types
  // --------------------

  typedef logic [addr_width-1:0] ram_addr_t;

  // source of the current access
  typedef enum logic {
    MODE_FUNC  = 1'b0,
    MODE_MBIST = 1'b1
  } access_mode_e;

endpackage : ram_access_pkg

`default_nettype wire

// File: ram_port_if.sv
/*
 * Write and read port of the RAM array.
 * Driven by the access controller, received by the array,
 * and watched by the capture stage for bypass data.
 */

`default_nettype none

interface ram_port_if #(
  parameter int word_width = ram_access_pkg::word_width_default
) ();
  import ram_access_pkg::*;

  // write port, one-cycle strobe
  logic                  we;
  ram_addr_t             wa;
  logic [word_width-1:0] wdata;

  // read port, one-cycle strobe
  logic                  re;
  ram_addr_t             ra;

  modport ctrl (output we, output wa, output wdata, output re, output ra);

  modport array (input we, input wa, input wdata, input re, input ra);

  // capture stage only needs the write word for ram bypass
  modport monitor (input wdata);

endinterface : ram_port_if

`default_nettype wire

// File: ram_access_ctrl.sv
/*
 * Access controller for the RAM wrapper.
 * Holds the MBIST mode register, selects functional or MBIST
 * access for both ports, and applies write inhibit.
 */

`default_nettype none

module ram_access_ctrl #(
  parameter int ram_depth  = ram_access_pkg::ram_depth_default,
  parameter int word_width = ram_access_pkg::word_width_default
) (
  input  logic                                         clk,
  input  logic                                         mbist_ramaccess_rst_,
  // functional ports
  input  logic                                         we,
  input  logic                                         re,
  input  ram_access_pkg::ram_addr_t                    wa,
  input  ram_access_pkg::ram_addr_t                    ra,
  input  logic [ram_access_pkg::data_width_default-1:0] di,
  input  logic                                         write_inh,
  // mbist port
  input  logic                                         mbist_en_sync,
  input  logic                                         mbist_we_w0,
  input  logic                                         mbist_ce_r0,
  input  ram_access_pkg::ram_addr_t                    mbist_wa_w0,
  input  ram_access_pkg::ram_addr_t                    mbist_ra_r0,
  input  logic [ram_access_pkg::pattern_width-1:0]     mbist_di_w0,
  // selected access
  output ram_access_pkg::access_mode_e                 mode,
  ram_port_if.ctrl                                     port
);
  import ram_access_pkg::*;

  localparam int pad_width      = word_width - data_width_default;
  localparam int pattern_copies = word_width / pattern_width;

  logic                  sel_we;
  logic                  sel_re;
  ram_addr_t             sel_wa;
  ram_addr_t             sel_ra;
  logic [word_width-1:0] func_word;
  logic [word_width-1:0] mbist_word;
  logic [word_width-1:0] sel_wdata;

  // --------------------
  // size checks
  // --------------------

  if (ram_depth > (1 << addr_width)) begin : g_depth_check
    $error("ram_depth does not fit in the address width");
  end

  if ((word_width % pattern_width) != 0 || word_width <= data_width_default) begin : g_width_check
    $error("word_width must hold the data and a whole number of patterns");
  end

  // --------------------
  // mbist mode register
  // --------------------

  // requests on the mbist port count from the second edge after mbist_en_sync rises
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      mode <= MODE_FUNC;
    end else begin
      mode <= mbist_en_sync ? MODE_MBIST : MODE_FUNC;
    end
  end

  // --------------------
  // port selection
  // --------------------

  // spare top bit is zero on the functional path
  assign func_word  = {{pad_width{1'b0}}, di};
  assign mbist_word = {pattern_copies{mbist_di_w0}};

  always_comb begin
    if (mode == MODE_MBIST) begin
      sel_we    = mbist_we_w0;
      sel_wa    = mbist_wa_w0;
      sel_wdata = mbist_word;
      sel_re    = mbist_ce_r0;
      sel_ra    = mbist_ra_r0;
    end else begin
      sel_we    = we;
      sel_wa    = wa;
      sel_wdata = func_word;
      sel_re    = re;
      sel_ra    = ra;
    end
  end

  // write inhibit blocks both sources
  assign port.we    = sel_we & ~write_inh;
  assign port.wa    = sel_wa;
  assign port.wdata = sel_wdata;
  assign port.re    = sel_re;
  assign port.ra    = sel_ra;

endmodule : ram_access_ctrl

`default_nettype wire

// File: ram_array.sv
/*
 * Two-port storage array.
 * Synchronous write, registered synchronous read that holds
 * the last word read, and address range assertions.
 */

`default_nettype none

module ram_array #(
  parameter int ram_depth  = ram_access_pkg::ram_depth_default,
  parameter int word_width = ram_access_pkg::word_width_default
) (
  input  logic                  clk,
  ram_port_if.array             port,
  output logic [word_width-1:0] ram_q
);

  logic [word_width-1:0] mem [ram_depth];

  // --------------------
  // write port
  // --------------------

  always_ff @(posedge clk) begin
    if (port.we) begin
      mem[port.wa] <= port.wdata;
    end
  end

  // --------------------
  // read port
  // --------------------

  // ram_q keeps the previous word until the next read strobe
  always_ff @(posedge clk) begin
    if (port.re) begin
      ram_q <= mem[port.ra];
    end
  end

  // --------------------
  // checks
  // --------------------

  // addresses come from either source through the controller mux
  a_wa_in_range: assert property (
    @(posedge clk) port.we |-> (int'(port.wa) < ram_depth)
  ) else $error("write address %0d beyond ram depth", port.wa);

  a_ra_in_range: assert property (
    @(posedge clk) port.re |-> (int'(port.ra) < ram_depth)
  ) else $error("read address %0d beyond ram depth", port.ra);

endmodule : ram_array

`default_nettype wire

// File: ram_capture.sv
/*
 * Output capture stage.
 * Delays the MBIST read strobe, builds the capture enable,
 * muxes array output against bypass data, and holds
 * the captured word for dout and mbist_do_r0.
 */

`default_nettype none

module ram_capture #(
  parameter int word_width = ram_access_pkg::word_width_default
) (
  input  logic                         clk,
  input  logic                         mbist_ramaccess_rst_,
  input  ram_access_pkg::access_mode_e mode,
  input  logic                         mbist_ce_r0,
  input  logic                         ore,
  input  logic                         scan_ramtms,
  input  logic                         ary_read_inh,
  input  logic [word_width-1:0]        ram_q,
  ram_port_if.monitor                  port,
  output logic [word_width-1:0]        data_q
);
  import ram_access_pkg::*;

  logic                  mbist_ce_r0_1p;
  logic                  ram_bypass;
  logic                  capture_en;
  logic [word_width-1:0] capture_d;

  // --------------------
  // mbist read strobe delay
  // --------------------

  // array data for an mbist read is ready one edge after the strobe
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      mbist_ce_r0_1p <= 1'b0;
    end else begin
      mbist_ce_r0_1p <= mbist_ce_r0;
    end
  end

  // --------------------
  // capture enable and data
  // --------------------

  // ore is ignored while mbist owns the ports
  assign capture_en = (mode == MODE_FUNC) ? ore : mbist_ce_r0_1p;

  // bypass takes the write word of the current cycle
  assign ram_bypass = scan_ramtms | ary_read_inh;
  assign capture_d  = ram_bypass ? port.wdata : ram_q;

  // --------------------
  // output register
  // --------------------

  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      data_q <= '0;
    end else if (capture_en) begin
      data_q <= capture_d;
    end
  end

  // mode comes from the controller register and ore from outside
  a_capture_en_known: assert property (
    @(posedge clk) disable iff (!mbist_ramaccess_rst_) !$isunknown(capture_en)
  ) else $error("capture enable is unknown");

endmodule : ram_capture

`default_nettype wire

// File: ram_access_top.sv
/*
 * Top level of the RAM access wrapper.
 * Sets the array sizes and wires the controller, the
 * 80 x 66 array and the capture stage behind plain ports.
 */

`default_nettype none

module ram_access_top (
  input  logic                                          clk,
  input  logic                                          mbist_ramaccess_rst_,
  // functional ports
  input  logic                                          we,
  input  logic                                          re,
  input  logic                                          ore,
  input  logic [ram_access_pkg::addr_width-1:0]         wa,
  input  logic [ram_access_pkg::addr_width-1:0]         ra,
  input  logic [ram_access_pkg::data_width_default-1:0] di,
  output logic [ram_access_pkg::data_width_default-1:0] dout,
  // test controls
  input  logic                                          write_inh,
  input  logic                                          scan_ramtms,
  input  logic                                          ary_read_inh,
  // mbist port
  input  logic                                          mbist_en_sync,
  input  logic                                          mbist_we_w0,
  input  logic                                          mbist_ce_r0,
  input  logic [ram_access_pkg::addr_width-1:0]         mbist_wa_w0,
  input  logic [ram_access_pkg::addr_width-1:0]         mbist_ra_r0,
  input  logic [ram_access_pkg::pattern_width-1:0]      mbist_di_w0,
  output logic [ram_access_pkg::word_width_default-1:0] mbist_do_r0
);
  import ram_access_pkg::*;

  localparam int ram_depth  = ram_depth_default;
  localparam int word_width = word_width_default;

  access_mode_e          mode;
  logic [word_width-1:0] ram_q;
  logic [word_width-1:0] data_q;

  ram_port_if #(.word_width(word_width)) port_if ();

  ram_access_ctrl #(
    .ram_depth  (ram_depth),
    .word_width (word_width)
  ) u_ctrl (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .we                   (we),
    .re                   (re),
    .wa                   (wa),
    .ra                   (ra),
    .di                   (di),
    .write_inh            (write_inh),
    .mbist_en_sync        (mbist_en_sync),
    .mbist_we_w0          (mbist_we_w0),
    .mbist_ce_r0          (mbist_ce_r0),
    .mbist_wa_w0          (mbist_wa_w0),
    .mbist_ra_r0          (mbist_ra_r0),
    .mbist_di_w0          (mbist_di_w0),
    .mode                 (mode),
    .port                 (port_if.ctrl)
  );

  ram_array #(
    .ram_depth  (ram_depth),
    .word_width (word_width)
  ) u_array (
    .clk   (clk),
    .port  (port_if.array),
    .ram_q (ram_q)
  );

  ram_capture #(
    .word_width (word_width)
  ) u_capture (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .mode                 (mode),
    .mbist_ce_r0          (mbist_ce_r0),
    .ore                  (ore),
    .scan_ramtms          (scan_ramtms),
    .ary_read_inh         (ary_read_inh),
    .ram_q                (ram_q),
    .port                 (port_if.monitor),
    .data_q               (data_q)
  );

  // functional output drops the spare bit
  assign dout        = data_q[data_width_default-1:0];
  assign mbist_do_r0 = data_q;

endmodule : ram_access_top

`default_nettype wire

// File: ram_access_tb_tasks.svh
/*
 * Testbench tasks: bounded wait for reset release,
 * drive of one table step onto the DUT inputs,
 * and the output check with mismatch reports.
 */

`ifndef ram_access_tb_tasks_svh
`define ram_access_tb_tasks_svh

task automatic wait_reset_release();
  int cycles;
  cycles = 0;
  while (mbist_ramaccess_rst_ !== 1'b1 && cycles < wait_limit) begin
    @(posedge clk);
    cycles++;
  end
  if (mbist_ramaccess_rst_ !== 1'b1) begin
    $display("reset was still asserted after %0d cycles", wait_limit);
    timeouts++;
  end
endtask

task automatic drive_step(input step_t s);
  we            = s.we;
  re            = s.re;
  ore           = s.ore;
  wa            = s.wa;
  ra            = s.ra;
  di            = s.di;
  write_inh     = s.inh;
  scan_ramtms   = s.tms;
  ary_read_inh  = s.rinh;
  mbist_en_sync = s.men;
  mbist_we_w0   = s.mwe;
  mbist_ce_r0   = s.mce;
  mbist_wa_w0   = s.mwa;
  mbist_ra_r0   = s.mra;
  mbist_di_w0   = s.mdi;
endtask

task automatic check_step(input int idx, input step_t s);
  if (s.chk) begin
    if (dout !== s.exp[data_width_default-1:0]) begin
      $display("MISMATCH at %0t: step %0d dout %h, expected %h",
               $time, idx, dout, s.exp[data_width_default-1:0]);
      errors++;
    end
    if (mbist_do_r0 !== s.exp) begin
      $display("MISMATCH at %0t: step %0d mbist_do_r0 %h, expected %h",
               $time, idx, mbist_do_r0, s.exp);
      errors++;
    end
  end
endtask

`endif

// File: ram_access_tb.sv
/*
 * Testbench for the RAM access wrapper.
 * Clock, reset, DUT instance, stimulus table built against
 * a reference model, the step loop and the final report.
 */

`default_nettype none

module ram_access_tb;
  import ram_access_pkg::*;

  localparam int pattern_copies = word_width_default / pattern_width;
  localparam int wait_limit     = 100;
  localparam int run_limit      = 2000;

  typedef logic [word_width_default-1:0] word_t;

  // one cycle of inputs and the expected output after its edge
  typedef struct packed {
    logic                          we;
    logic                          re;
    logic                          ore;
    ram_addr_t                     wa;
    ram_addr_t                     ra;
    logic [data_width_default-1:0] di;
    logic                          inh;
    logic                          tms;
    logic                          rinh;
    logic                          men;
    logic                          mwe;
    logic                          mce;
    ram_addr_t                     mwa;
    ram_addr_t                     mra;
    logic [pattern_width-1:0]      mdi;
    logic                          chk;
    word_t                         exp;
  } step_t;

  logic                          clk = 1'b0;
  logic                          mbist_ramaccess_rst_;
  logic                          we;
  logic                          re;
  logic                          ore;
  logic [addr_width-1:0]         wa;
  logic [addr_width-1:0]         ra;
  logic [data_width_default-1:0] di;
  logic [data_width_default-1:0] dout;
  logic                          write_inh;
  logic                          scan_ramtms;
  logic                          ary_read_inh;
  logic                          mbist_en_sync;
  logic                          mbist_we_w0;
  logic                          mbist_ce_r0;
  logic [addr_width-1:0]         mbist_wa_w0;
  logic [addr_width-1:0]         mbist_ra_r0;
  logic [pattern_width-1:0]      mbist_di_w0;
  logic [word_width_default-1:0] mbist_do_r0;

  int    errors = 0;
  int    timeouts = 0;
  step_t steps[$];

  // reference model state, as seen between two edges
  word_t model_mem [ram_depth_default];
  logic  model_mbist = 1'b0;
  logic  model_ce_1p = 1'b0;
  word_t model_q = 'x;
  word_t model_out = '0;

  ram_access_top ram_access_top_inst (.*);

  `include "ram_access_tb_tasks.svh"

  always #5 clk = ~clk;

  initial begin
    mbist_ramaccess_rst_ = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    mbist_ramaccess_rst_ = 1'b1;
  end

  function automatic logic [data_width_default-1:0] rand_data();
    logic [95:0] r;
    r = {$urandom(), $urandom(), $urandom()};
    return r[data_width_default-1:0];
  endfunction

  // --------------------
  // reference model
  // --------------------

  // advance the model by one edge and append the step with its expected word
  task automatic add_step(input step_t s);
    step_t t;
    word_t word;
    logic  cap_en;
    t      = s;
    word   = model_mbist ? {pattern_copies{s.mdi}} : word_t'(s.di);
    cap_en = model_mbist ? model_ce_1p : s.ore;
    if (cap_en) begin
      model_out = (s.tms | s.rinh) ? word : model_q;
    end
    // read sees the word from before a write in the same cycle
    if (model_mbist ? s.mce : s.re) begin
      model_q = model_mem[model_mbist ? s.mra : s.ra];
    end
    if ((model_mbist ? s.mwe : s.we) && !s.inh) begin
      model_mem[model_mbist ? s.mwa : s.wa] = word;
    end
    model_mbist = s.men;
    model_ce_1p = s.mce;
    t.exp = model_out;
    steps.push_back(t);
  endtask

  task automatic push_write(input ram_addr_t addr, input logic inh);
    step_t s;
    s     = '0;
    s.we  = 1'b1;
    s.wa  = addr;
    s.di  = rand_data();
    s.inh = inh;
    add_step(s);
  endtask

  // read strobe, then ore on the next cycle with a check
  task automatic push_read_capture(input ram_addr_t addr);
    step_t s;
    s    = '0;
    s.re = 1'b1;
    s.ra = addr;
    add_step(s);
    s     = '0;
    s.ore = 1'b1;
    s.chk = 1'b1;
    add_step(s);
  endtask

  task automatic build_table();
    step_t                    s;
    ram_addr_t                func_addr [3];
    logic [pattern_width-1:0] pat [3];
    func_addr = '{7'd0, 7'd79, 7'd40};
    pat       = '{2'b01, 2'b10, 2'b11};
    for (int k = 0; k < 3; k++) begin
      push_write(func_addr[k], 1'b0);
    end
    for (int k = 0; k < 3; k++) begin
      push_read_capture(func_addr[k]);
    end
    // inhibited write must leave the word at 40
    push_write(7'd40, 1'b1);
    push_read_capture(7'd40);
    // bypass through scan_ramtms, then through ary_read_inh
    s     = '0;
    s.tms = 1'b1;
    s.ore = 1'b1;
    s.di  = rand_data();
    s.chk = 1'b1;
    add_step(s);
    s.tms  = 1'b0;
    s.rinh = 1'b1;
    s.di   = rand_data();
    add_step(s);
    // reads without ore, dout holds
    s     = '0;
    s.re  = 1'b1;
    s.chk = 1'b1;
    add_step(s);
    s.ra = 7'd79;
    add_step(s);
    s.re = 1'b0;
    add_step(s);
    // mbist owns the ports from the second edge
    s     = '0;
    s.men = 1'b1;
    add_step(s);
    add_step(s);
    for (int k = 0; k < 3; k++) begin
      s.mwe = 1'b1;
      s.mwa = ram_addr_t'(10 + k);
      s.mdi = pat[k];
      add_step(s);
    end
    s.mwe = 1'b0;
    // back to back reads, ore toggled and ignored
    for (int k = 0; k < 3; k++) begin
      s.mce = 1'b1;
      s.mra = ram_addr_t'(10 + k);
      s.ore = (k == 0);
      s.chk = 1'b1;
      add_step(s);
    end
    s.mce = 1'b0;
    s.ore = 1'b1;
    add_step(s);
    add_step(s);
    // functional ports again after mbist_en_sync falls
    s = '0;
    add_step(s);
    push_write(7'd5, 1'b0);
    push_read_capture(7'd5);
    push_read_capture(7'd79);
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    step_t idle;
    idle = '0;
    void'($urandom(32'hddb4_cb43));
    drive_step(idle);
    build_table();
    wait_reset_release();
    if (timeouts == 0) begin
      for (int i = 0; i < steps.size(); i++) begin
        @(posedge clk);
        #1;
        if (i > 0) begin
          check_step(i - 1, steps[i-1]);
        end
        drive_step(steps[i]);
      end
      @(posedge clk);
      #1;
      check_step(steps.size() - 1, steps[steps.size()-1]);
    end
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // overall run limit
  initial begin
    repeat (run_limit) @(posedge clk);
    $display("run did not finish within %0d cycles", run_limit);
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts + 1);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule : ram_access_tb

`default_nettype wire

// File: compile.f
+incdir+.
ram_access_pkg.sv
ram_port_if.sv
ram_access_ctrl.sv
ram_array.sv
ram_capture.sv
ram_access_top.sv
ram_access_tb.sv

// File: Makefile
# Verilator build for the RAM access wrapper testbench

TOP := ram_access_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then \
	  echo "simulation failed, see sim.log"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
